/* flist.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/bus_pkg.sv
verilog/wait_lfsr.sv
verilog/sram_slave.sv
verilog/lsu_ctrl.sv
verilog/lsu_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

/* tb/lsu_checker.sv */
`include "lsu_settings.svh"

module lsu_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   ren,
  input logic                   wen,
  input logic [`LSU_ADDR_W-1:0] addr,
  input lsu_pkg::mem_size_e     size,
  input logic                   read_done,
  input logic                   write_done
);
  timeunit 1ns;
  timeprecision 1ps;

  done_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(read_done && write_done))
    else $error("read_done and write_done high in the same cycle");

  read_done_pulse: assert property (@(posedge clk) disable iff (rst)
    read_done |=> !read_done)
    else $error("read_done high for more than one cycle");

  write_done_pulse: assert property (@(posedge clk) disable iff (rst)
    write_done |=> !write_done)
    else $error("write_done high for more than one cycle");

  half_aligned: assert property (@(posedge clk) disable iff (rst)
    ((ren || wen) && (size == lsu_pkg::size_half)) |-> (addr[0] == 1'b0))
    else $error("half access at an odd address");

  word_aligned: assert property (@(posedge clk) disable iff (rst)
    ((ren || wen) && (size == lsu_pkg::size_word)) |-> (addr[1:0] == 2'b00))
    else $error("word access not 4-aligned");

  req_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(ren && wen))
    else $error("ren and wen high together");

endmodule

bind lsu_top lsu_checker u_checker (
  .clk        (clk),
  .rst        (rst),
  .ren        (ren),
  .wen        (wen),
  .addr       (addr),
  .size       (size),
  .read_done  (read_done),
  .write_done (write_done)
);

/* tb/lsu_tb.sv */
`include "lsu_settings.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_random    = 600;
  localparam int cycle_limit = n_random * 30 + 100;
  localparam int read_min    = 3;
  localparam int read_max    = 17;
  localparam int write_min   = 4;
  localparam int write_max   = 26;

  logic                   clk;
  logic                   rst;
  logic                   ren;
  logic                   wen;
  logic [`LSU_ADDR_W-1:0] addr;
  logic [`LSU_DATA_W-1:0] wdata;
  lsu_pkg::mem_size_e     size;
  logic                   sext;
  logic [`LSU_DATA_W-1:0] rdata;
  logic                   read_done;
  logic                   write_done;

  logic [7:0]             model [256]; // byte image of the first 64 words.
  bit                     written [256];
  logic [`LSU_DATA_W-1:0] last_load;
  bit                     last_load_known;
  integer                 seed;
  int                     cycles;

  lsu_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .ren        (ren),
    .wen        (wen),
    .addr       (addr),
    .wdata      (wdata),
    .size       (size),
    .sext       (sext),
    .rdata      (rdata),
    .read_done  (read_done),
    .write_done (write_done)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s got %h, expected %h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

  function automatic int num_bytes(input lsu_pkg::mem_size_e sz);
    case (sz)
      lsu_pkg::size_byte: return 1;
      lsu_pkg::size_half: return 2;
      default:            return 4;
    endcase
  endfunction

  function automatic bit bytes_known(input int a, input lsu_pkg::mem_size_e sz);
    bit known;
    known = 1'b1;
    for (int i = 0; i < num_bytes(sz); i++) begin
      if (!written[a + i]) known = 1'b0;
    end
    return known;
  endfunction

  // little-endian gather followed by extension by size and sext.
  function automatic logic [31:0] expected_load(input int a, input lsu_pkg::mem_size_e sz,
                                                input logic sx);
    logic [31:0] raw;
    raw = '0;
    for (int i = 0; i < num_bytes(sz); i++) begin
      raw[8*i +: 8] = model[a + i];
    end
    if (sx && (sz == lsu_pkg::size_byte) && raw[7]) raw[31:8] = '1;
    if (sx && (sz == lsu_pkg::size_half) && raw[15]) raw[31:16] = '1;
    return raw;
  endfunction

  // called 2 ns after an edge with the unit idle and returns the same way.
  task automatic run_access(input bit is_write, input int a, input logic [31:0] d,
                            input lsu_pkg::mem_size_e sz, input logic sx);
    int n;
    int lo;
    int hi;
    bit seen;
    lo   = is_write ? write_min : read_min;
    hi   = is_write ? write_max : read_max;
    n    = 0;
    seen = 1'b0;
    ren   = !is_write;
    wen   = is_write;
    addr  = a;
    wdata = d;
    size  = sz;
    sext  = sx;
    while (!seen) begin
      @(posedge clk);
      #2;
      n++;
      ren = 1'b0;
      wen = 1'b0;
      if (read_done && write_done) begin
        abort_run("read_done and write_done were high in the same cycle");
      end else if (is_write ? read_done : write_done) begin
        abort_run($sformatf("wrong done pulse for a request at address %h", a));
      end else if (is_write ? write_done : read_done) begin
        if (n < lo) abort_run($sformatf("done pulse after %0d cycles, before the minimum", n));
        seen = 1'b1;
      end else if (n >= hi) begin
        abort_run($sformatf("no done pulse within %0d cycles at address %h", hi, a));
      end
    end
    if (is_write) begin
      if (last_load_known) begin
        check_val("rdata", rdata, last_load); // a store leaves rdata alone.
      end
      for (int i = 0; i < num_bytes(sz); i++) begin
        model[a + i]   = d[8*i +: 8];
        written[a + i] = 1'b1;
      end
    end else begin
      last_load_known = bytes_known(a, sz);
      if (last_load_known) begin
        last_load = expected_load(a, sz, sx);
        check_val("rdata", rdata, last_load);
      end
    end
    @(posedge clk);
    #2;
    check_val("read_done", read_done, 32'h0);
    check_val("write_done", write_done, 32'h0);
  endtask

  task automatic store(input int a, input logic [31:0] d, input lsu_pkg::mem_size_e sz);
    run_access(1'b1, a, d, sz, 1'b0);
  endtask

  task automatic load(input int a, input lsu_pkg::mem_size_e sz, input logic sx);
    run_access(1'b0, a, 32'h0, sz, sx);
  endtask

  // every byte and half offset with and without sign extension.
  task automatic sign_pass(input int base, input logic [31:0] word);
    store(base, word, lsu_pkg::size_word);
    for (int off = 0; off < 4; off++) begin
      load(base + off, lsu_pkg::size_byte, 1'b0);
      load(base + off, lsu_pkg::size_byte, 1'b1);
    end
    for (int off = 0; off < 4; off += 2) begin
      load(base + off, lsu_pkg::size_half, 1'b0);
      load(base + off, lsu_pkg::size_half, 1'b1);
    end
    load(base, lsu_pkg::size_word, 1'b0);
    load(base, lsu_pkg::size_word, 1'b1);
  endtask

  initial begin
    int                 off;
    int                 pick;
    bit                 do_write;
    lsu_pkg::mem_size_e sz;
    seed            = 90594;
    cycles          = 0;
    last_load       = '0;
    last_load_known = 1'b0;
    clk             = 1'b0;
    rst             = 1'b1;
    ren             = 1'b0;
    wen             = 1'b0;
    addr            = '0;
    wdata           = '0;
    size            = lsu_pkg::size_word;
    sext            = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #2;
      check_val("read_done", read_done, 32'h0);
      check_val("write_done", write_done, 32'h0);
    end

    store(32'h10, 32'hdeadbeef, lsu_pkg::size_word);
    load(32'h10, lsu_pkg::size_word, 1'b0);
    check_val("rdata", rdata, 32'hdeadbeef);

    store(32'h11, 32'h000000a5, lsu_pkg::size_byte);
    store(32'h12, 32'h00001234, lsu_pkg::size_half);
    load(32'h10, lsu_pkg::size_word, 1'b0);
    check_val("rdata", rdata, 32'h1234a5ef); // lane 0 untouched.

    sign_pass(32'h20, 32'h807fff01);
    sign_pass(32'h24, 32'h7fff8000);

    for (int k = 0; k < n_random; k++) begin
      pick     = {$random(seed)} % 3;
      sz       = lsu_pkg::mem_size_e'(pick);
      do_write = {$random(seed)} % 2;
      off      = ({$random(seed)} % 64) * 4;
      if (sz == lsu_pkg::size_byte) off += {$random(seed)} % 4;
      if (sz == lsu_pkg::size_half) off += ({$random(seed)} % 2) * 2;
      if (do_write) begin
        store(off, $random(seed), sz);
      end else begin
        load(off, sz, {$random(seed)} % 2);
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

/* verilog/bus_pkg.sv */
package bus_pkg;

  // response code on the R and B channels.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  // per-direction state of the memory model.
  typedef enum logic [1:0] {
    sr_idle = 2'b00,
    sr_wait = 2'b01,
    sr_resp = 2'b10
  } sram_state_e;

endpackage

/* verilog/lsu_ctrl.sv */
`include "lsu_settings.svh"

module lsu_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ren,
  input  logic                     wen,
  input  logic [`LSU_ADDR_W-1:0]   addr,
  input  logic [`LSU_DATA_W-1:0]   wdata,
  input  lsu_pkg::mem_size_e       size,
  input  logic                     sext,
  output logic [`LSU_DATA_W-1:0]   rdata,
  output logic                     read_done,
  output logic                     write_done,
  output logic [`LSU_ADDR_W-1:0]   araddr,
  output logic                     arvalid,
  input  logic                     arready,
  output logic                     rready,
  input  logic [`LSU_DATA_W-1:0]   rdata_bus,
  input  bus_pkg::resp_e           rresp,
  input  logic                     rvalid,
  output logic [`LSU_ADDR_W-1:0]   awaddr,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [`LSU_DATA_W-1:0]   wdata_bus,
  output logic [`LSU_DATA_W/8-1:0] wstrb,
  output logic                     wvalid,
  input  logic                     wready,
  input  bus_pkg::resp_e           bresp,
  input  logic                     bvalid,
  output logic                     bready
);

  lsu_pkg::lsu_state_e      state;
  logic                     is_read;
  logic [1:0]               lane;
  logic [`LSU_DATA_W/8-1:0] strb_base;
  logic [`LSU_DATA_W-1:0]   shifted;
  logic [`LSU_DATA_W-1:0]   load_val;

  assign lane = addr[1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= lsu_pkg::st_idle;
      is_read <= 1'b0;
    end else begin
      case (state)
        lsu_pkg::st_idle: begin
          if (ren) begin
            state   <= lsu_pkg::st_raddr;
            is_read <= 1'b1;
          end else if (wen) begin
            state   <= lsu_pkg::st_waddr;
            is_read <= 1'b0;
          end
        end
        lsu_pkg::st_raddr: begin
          if (arready) begin
            state <= lsu_pkg::st_rdata;
          end
        end
        lsu_pkg::st_rdata: begin
          if (rvalid) begin // an error response reissues the read.
            state <= (rresp == bus_pkg::resp_okay) ? lsu_pkg::st_done : lsu_pkg::st_raddr;
          end
        end
        lsu_pkg::st_waddr: begin
          if (awready) begin
            state <= lsu_pkg::st_wdata;
          end
        end
        lsu_pkg::st_wdata: begin
          if (wready) begin
            state <= lsu_pkg::st_bresp;
          end
        end
        lsu_pkg::st_bresp: begin
          if (bvalid) begin
            state <= (bresp == bus_pkg::resp_okay) ? lsu_pkg::st_done : lsu_pkg::st_waddr;
          end
        end
        default: state <= lsu_pkg::st_idle; // st_done lasts one cycle.
      endcase
    end
  end

  // channel handshakes follow the state.
  assign arvalid = (state == lsu_pkg::st_raddr);
  assign rready  = (state == lsu_pkg::st_rdata);
  assign awvalid = (state == lsu_pkg::st_waddr);
  assign wvalid  = (state == lsu_pkg::st_wdata);
  assign bready  = (state == lsu_pkg::st_bresp);

  assign read_done  = (state == lsu_pkg::st_done) && is_read;
  assign write_done = (state == lsu_pkg::st_done) && !is_read;

  assign araddr = addr;
  assign awaddr = addr;

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        wdata_bus = {4{wdata[7:0]}};
        strb_base = 4'b0001;
      end
      lsu_pkg::size_half: begin
        wdata_bus = {2{wdata[15:0]}};
        strb_base = 4'b0011;
      end
      default: begin
        wdata_bus = wdata;
        strb_base = 4'b1111;
      end
    endcase
  end

  assign wstrb = strb_base << lane; // aligned, so no lane wraps.

  // move the addressed lane down to bit 0.
  assign shifted = rdata_bus >> {lane, 3'b000};

  always_comb begin
    case (size)
      lsu_pkg::size_byte: load_val = {{(`LSU_DATA_W-8){sext & shifted[7]}}, shifted[7:0]};
      lsu_pkg::size_half: load_val = {{(`LSU_DATA_W-16){sext & shifted[15]}}, shifted[15:0]};
      default:            load_val = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rvalid && rready && (rresp == bus_pkg::resp_okay)) begin
      rdata <= load_val; // held until the next load.
    end
  end

endmodule

/* verilog/lsu_pkg.sv */
package lsu_pkg;

  // access size of a core-side request.
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  // load/store controller states.
  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_raddr = 3'd1,
    st_rdata = 3'd2,
    st_waddr = 3'd3,
    st_wdata = 3'd4,
    st_bresp = 3'd5,
    st_done  = 3'd6
  } lsu_state_e;

endpackage

/* verilog/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// byte address width.
`define LSU_ADDR_W 32

// data word width, four byte lanes.
`define LSU_DATA_W 32

// memory depth in words, indexed by addr[11:2].
`define LSU_MEM_WORDS 1024

// wait count width, 0 to 7 extra cycles per channel.
`define LSU_WAIT_BITS 3

`endif

/* verilog/lsu_top.sv */
`include "lsu_settings.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ren,
  input  logic                   wen,
  input  logic [`LSU_ADDR_W-1:0] addr,
  input  logic [`LSU_DATA_W-1:0] wdata,
  input  lsu_pkg::mem_size_e     size,
  input  logic                   sext,
  output logic [`LSU_DATA_W-1:0] rdata,
  output logic                   read_done,
  output logic                   write_done
);

  logic [`LSU_ADDR_W-1:0]    araddr;
  logic                      arvalid;
  logic                      arready;
  logic                      rready;
  logic [`LSU_DATA_W-1:0]    rdata_bus;
  bus_pkg::resp_e            rresp;
  logic                      rvalid;
  logic [`LSU_ADDR_W-1:0]    awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [`LSU_DATA_W-1:0]    wdata_bus;
  logic [`LSU_DATA_W/8-1:0]  wstrb;
  logic                      wvalid;
  logic                      wready;
  logic                      bready;
  bus_pkg::resp_e            bresp;
  logic                      bvalid;
  logic [`LSU_WAIT_BITS-1:0] wait_val;

  lsu_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .ren        (ren),
    .wen        (wen),
    .addr       (addr),
    .wdata      (wdata),
    .size       (size),
    .sext       (sext),
    .rdata      (rdata),
    .read_done  (read_done),
    .write_done (write_done),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rready     (rready),
    .rdata_bus  (rdata_bus),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata_bus  (wdata_bus),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  sram_slave u_sram (
    .clk       (clk),
    .rst       (rst),
    .wait_val  (wait_val),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rready    (rready),
    .rdata_bus (rdata_bus),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata_bus (wdata_bus),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bready    (bready),
    .bresp     (bresp),
    .bvalid    (bvalid)
  );

  wait_lfsr u_lfsr (
    .clk      (clk),
    .rst      (rst),
    .wait_val (wait_val)
  );

endmodule

/* verilog/sram_slave.sv */
`include "lsu_settings.svh"

module sram_slave (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`LSU_WAIT_BITS-1:0] wait_val,
  input  logic [`LSU_ADDR_W-1:0]    araddr,
  input  logic                      arvalid,
  output logic                      arready,
  input  logic                      rready,
  output logic [`LSU_DATA_W-1:0]    rdata_bus,
  output bus_pkg::resp_e            rresp,
  output logic                      rvalid,
  input  logic [`LSU_ADDR_W-1:0]    awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`LSU_DATA_W-1:0]    wdata_bus,
  input  logic [`LSU_DATA_W/8-1:0]  wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  input  logic                      bready,
  output bus_pkg::resp_e            bresp,
  output logic                      bvalid
);

  logic [`LSU_DATA_W-1:0]              mem [`LSU_MEM_WORDS];
  bus_pkg::sram_state_e                rd_state;
  bus_pkg::sram_state_e                wr_state;
  logic [`LSU_WAIT_BITS-1:0]           rd_cnt;
  logic [`LSU_WAIT_BITS-1:0]           wr_cnt;
  logic                                aw_got;   // AW done, now serving W.
  logic                                wr_valid;
  logic                                rd_take;
  logic                                wr_take;
  logic [$clog2(`LSU_MEM_WORDS)-1:0]   rd_idx;
  logic [$clog2(`LSU_MEM_WORDS)-1:0]   wr_idx;

  assign rd_idx = araddr[$clog2(`LSU_MEM_WORDS)+1:2];

  // accept at once on a zero wait, else after the countdown.
  assign rd_take = arvalid &&
                   (((rd_state == bus_pkg::sr_idle) && (wait_val == '0)) ||
                    ((rd_state == bus_pkg::sr_wait) && (rd_cnt == '0)));

  assign arready = rd_take;
  assign rvalid  = (rd_state == bus_pkg::sr_resp) && (rd_cnt == '0);
  assign rresp   = bus_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= bus_pkg::sr_idle;
      rd_cnt   <= '0;
    end else begin
      case (rd_state)
        bus_pkg::sr_idle, bus_pkg::sr_wait: begin
          if (rd_take) begin
            rd_state <= bus_pkg::sr_resp;
            rd_cnt   <= wait_val; // response wait.
          end else if ((rd_state == bus_pkg::sr_idle) && arvalid) begin
            rd_state <= bus_pkg::sr_wait;
            rd_cnt   <= wait_val - 1'b1;
          end else if ((rd_state == bus_pkg::sr_wait) && (rd_cnt != '0)) begin
            rd_cnt <= rd_cnt - 1'b1;
          end
        end
        bus_pkg::sr_resp: begin
          if (rd_cnt != '0) begin
            rd_cnt <= rd_cnt - 1'b1;
          end else if (rready) begin
            rd_state <= bus_pkg::sr_idle;
          end
        end
        default: rd_state <= bus_pkg::sr_idle;
      endcase
    end
  end

  // the write side serves AW first, then W, with the same countdown.
  assign wr_valid = aw_got ? wvalid : awvalid;
  assign wr_take  = wr_valid &&
                    (((wr_state == bus_pkg::sr_idle) && (wait_val == '0)) ||
                     ((wr_state == bus_pkg::sr_wait) && (wr_cnt == '0)));

  assign awready = wr_take && !aw_got;
  assign wready  = wr_take && aw_got;
  assign bvalid  = (wr_state == bus_pkg::sr_resp) && (wr_cnt == '0);
  assign bresp   = bus_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= bus_pkg::sr_idle;
      wr_cnt   <= '0;
      aw_got   <= 1'b0;
    end else begin
      case (wr_state)
        bus_pkg::sr_idle, bus_pkg::sr_wait: begin
          if (wr_take && !aw_got) begin
            wr_state <= bus_pkg::sr_idle; // wait for W.
            aw_got   <= 1'b1;
          end else if (wr_take) begin
            wr_state <= bus_pkg::sr_resp;
            wr_cnt   <= wait_val;
            aw_got   <= 1'b0;
          end else if ((wr_state == bus_pkg::sr_idle) && wr_valid) begin
            wr_state <= bus_pkg::sr_wait;
            wr_cnt   <= wait_val - 1'b1;
          end else if ((wr_state == bus_pkg::sr_wait) && (wr_cnt != '0)) begin
            wr_cnt <= wr_cnt - 1'b1;
          end
        end
        bus_pkg::sr_resp: begin
          if (wr_cnt != '0) begin
            wr_cnt <= wr_cnt - 1'b1;
          end else if (bready) begin
            wr_state <= bus_pkg::sr_idle;
          end
        end
        default: wr_state <= bus_pkg::sr_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_take) begin
      rdata_bus <= mem[rd_idx];
    end
    if (awready) begin
      wr_idx <= awaddr[$clog2(`LSU_MEM_WORDS)+1:2];
    end
    if (wready) begin
      for (int i = 0; i < `LSU_DATA_W/8; i++) begin
        if (wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= wdata_bus[8*i +: 8];
        end
      end
    end
  end

endmodule

/* verilog/wait_lfsr.sv */
`include "lsu_settings.svh"

module wait_lfsr (
  input  logic                      clk,
  input  logic                      rst,
  output logic [`LSU_WAIT_BITS-1:0] wait_val
);

  logic [7:0] lfsr;
  logic       feedback;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length.
  assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= 8'hA5; // any nonzero seed.
    end else begin
      lfsr <= {lfsr[6:0], feedback};
    end
  end

  assign wait_val = lfsr[`LSU_WAIT_BITS-1:0];

endmodule
